/* include/wisc_defs.svh */
// Width, register count and reset vector of the 16-bit teaching core
`ifndef WISC_DEFS_SVH
`define WISC_DEFS_SVH

// Data and address width
`define WORD_W 16

// Register file size
`define REG_CNT 8
`define REG_IDX_W 3

// First fetch address
`define RESET_PC 16'h0000

`endif

/* src/wiscPkg.sv */
// Enumerated types for the opcodes and control fields of the teaching core
package wiscPkg;

	// Major opcode in bits 15:11
	typedef enum logic [4:0] {
		OP_HALT = 5'b00000, OP_NOP = 5'b00001, OP_SIIC = 5'b00010, OP_RTI = 5'b00011,
		OP_J = 5'b00100, OP_JR = 5'b00101, OP_JAL = 5'b00110, OP_JALR = 5'b00111,
		OP_ADDI = 5'b01000, OP_SUBI = 5'b01001, OP_XORI = 5'b01010, OP_ANDI = 5'b01011,
		OP_BEQZ = 5'b01100, OP_BNEZ = 5'b01101, OP_BLTZ = 5'b01110, OP_BGEZ = 5'b01111,
		OP_ST = 5'b10000, OP_LD = 5'b10001, OP_SLBI = 5'b10010, OP_STU = 5'b10011,
		OP_ROLI = 5'b10100, OP_SLLI = 5'b10101, OP_RORI = 5'b10110, OP_SRLI = 5'b10111,
		OP_LBI = 5'b11000, OP_BTR = 5'b11001, OP_RTYPE_SHIFT = 5'b11010,
		OP_RTYPE_ARITH = 5'b11011, OP_SEQ = 5'b11100, OP_SLT = 5'b11101,
		OP_SLE = 5'b11110, OP_SCO = 5'b11111
	} opcodeT;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUBR, ALU_XOR, ALU_AND,
		ALU_ANDN, ALU_ROL, ALU_SLL, ALU_ROR,
		ALU_SRL, ALU_SEQ, ALU_SLT, ALU_SLE,
		ALU_SCO, ALU_BTR, ALU_PASSB, ALU_SLBI
	} aluOpT;

	typedef enum logic [2:0] {
		IMM_ZE5, IMM_SE5, IMM_SE8, IMM_ZE8, IMM_SE11
	} immSelT;

	// Write register field
	typedef enum logic [1:0] {
		DEST_RT, DEST_RD, DEST_RS, DEST_R7
	} destSelT;

	typedef enum logic [1:0] {
		WB_ALU, WB_MEM, WB_LINK
	} wbSelT;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ
	} brCondT;

endpackage

/* src/ctrlIf.sv */
// Decoded control bundle shared by the decoder and the datapath blocks
`timescale 1ns/1ns

interface ctrlIf;
	import wiscPkg::*;

	logic regWrite;
	destSelT destSel;
	logic aluSrc;
	aluOpT aluOp;
	immSelT immSel;
	logic memWrite;
	logic memRead;
	wbSelT wbSel;
	brCondT brCond;
	logic jump;
	logic jumpReg;
	logic halt;

	modport decoder (
		output regWrite, destSel, aluSrc, aluOp, immSel, memWrite, memRead,
		output wbSel, brCond, jump, jumpReg, halt
	);

	modport datapath (
		input regWrite, destSel, aluSrc, aluOp, immSel, memWrite, memRead,
		input wbSel, brCond, jump, jumpReg, halt
	);

endinterface

/* src/control.sv */
// Instruction decoder from opcode and function bits to the control bundle
`timescale 1ns/1ns
`include "wisc_defs.svh"

module control (
	input logic [`WORD_W-1:0] instr,
	ctrlIf.decoder ctrl
);
	import wiscPkg::*;

	opcodeT opcode;

	assign opcode = opcodeT'(instr[15:11]);

	always_comb begin
		// Nop behaviour unless the opcode says otherwise
		ctrl.regWrite = 1'b0;
		ctrl.destSel = DEST_RT;
		ctrl.aluSrc = 1'b0;
		ctrl.aluOp = ALU_ADD;
		ctrl.immSel = IMM_SE5;
		ctrl.memWrite = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.wbSel = WB_ALU;
		ctrl.brCond = BR_NONE;
		ctrl.jump = 1'b0;
		ctrl.jumpReg = 1'b0;
		ctrl.halt = 1'b0;

		case (opcode)
			OP_HALT: ctrl.halt = 1'b1;
			OP_ADDI, OP_SUBI, OP_XORI, OP_ANDI,
			OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.immSel = (opcode == OP_ADDI || opcode == OP_SUBI) ? IMM_SE5 : IMM_ZE5;
				case (opcode)
					OP_ADDI: ctrl.aluOp = ALU_ADD;
					OP_SUBI: ctrl.aluOp = ALU_SUBR;
					OP_XORI: ctrl.aluOp = ALU_XOR;
					OP_ANDI: ctrl.aluOp = ALU_AND;
					OP_ROLI: ctrl.aluOp = ALU_ROL;
					OP_SLLI: ctrl.aluOp = ALU_SLL;
					OP_RORI: ctrl.aluOp = ALU_ROR;
					default: ctrl.aluOp = ALU_SRL;
				endcase
			end
			OP_ST: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			OP_LD: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.wbSel = WB_MEM;
			end
			// Store, then write the address back to Rs
			OP_STU: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = DEST_RS;
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			OP_BTR, OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = DEST_RD;
				case (opcode)
					OP_BTR: ctrl.aluOp = ALU_BTR;
					OP_SEQ: ctrl.aluOp = ALU_SEQ;
					OP_SLT: ctrl.aluOp = ALU_SLT;
					OP_SLE: ctrl.aluOp = ALU_SLE;
					default: ctrl.aluOp = ALU_SCO;
				endcase
			end
			OP_RTYPE_ARITH: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = DEST_RD;
				case (instr[1:0])
					2'b00: ctrl.aluOp = ALU_ADD;
					2'b01: ctrl.aluOp = ALU_SUBR;
					2'b10: ctrl.aluOp = ALU_XOR;
					default: ctrl.aluOp = ALU_ANDN;
				endcase
			end
			OP_RTYPE_SHIFT: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = DEST_RD;
				case (instr[1:0])
					2'b00: ctrl.aluOp = ALU_ROL;
					2'b01: ctrl.aluOp = ALU_SLL;
					2'b10: ctrl.aluOp = ALU_ROR;
					default: ctrl.aluOp = ALU_SRL;
				endcase
			end
			OP_BEQZ: ctrl.brCond = BR_EQZ;
			OP_BNEZ: ctrl.brCond = BR_NEZ;
			OP_BLTZ: ctrl.brCond = BR_LTZ;
			OP_BGEZ: ctrl.brCond = BR_GEZ;
			OP_LBI, OP_SLBI: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = DEST_RS;
				ctrl.aluSrc = 1'b1;
				ctrl.immSel = (opcode == OP_LBI) ? IMM_SE8 : IMM_ZE8;
				ctrl.aluOp = (opcode == OP_LBI) ? ALU_PASSB : ALU_SLBI;
			end
			OP_J, OP_JAL: begin
				ctrl.jump = 1'b1;
				ctrl.immSel = IMM_SE11;
				ctrl.regWrite = (opcode == OP_JAL);
				ctrl.destSel = DEST_R7;
				ctrl.wbSel = WB_LINK;
			end
			// Target is Rs plus the 8-bit immediate
			OP_JR, OP_JALR: begin
				ctrl.jump = 1'b1;
				ctrl.jumpReg = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.immSel = IMM_SE8;
				ctrl.regWrite = (opcode == OP_JALR);
				ctrl.destSel = DEST_R7;
				ctrl.wbSel = WB_LINK;
			end
			default: ;
		endcase
	end

endmodule

/* src/regFile.sv */
// Eight-entry register file, two combinational reads and one clocked write
`timescale 1ns/1ns
`include "wisc_defs.svh"

module regFile (
	input logic clk,
	input logic arstN,
	input logic [`REG_IDX_W-1:0] rdAddrA,
	input logic [`REG_IDX_W-1:0] rdAddrB,
	input logic wrEn,
	input logic [`REG_IDX_W-1:0] wrAddr,
	input logic [`WORD_W-1:0] wrData,
	output logic [`WORD_W-1:0] rdDataA,
	output logic [`WORD_W-1:0] rdDataB
);

	logic [`WORD_W-1:0] regs [`REG_CNT];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// No bypass so a write shows up the next cycle
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

/* src/execute.sv */
// Immediate extension, operand select and ALU of the teaching core
`timescale 1ns/1ns
`include "wisc_defs.svh"

module execute (
	input logic [`WORD_W-1:0] instr,
	ctrlIf.datapath ctrl,
	input logic [`WORD_W-1:0] rsData,
	input logic [`WORD_W-1:0] rtData,
	output logic [`WORD_W-1:0] aluResult
);
	import wiscPkg::*;

	logic [`WORD_W-1:0] imm;
	logic [`WORD_W-1:0] opB;
	logic [`WORD_W-1:0] btrA;
	logic [`WORD_W:0] sumFull;
	logic [2*`WORD_W-1:0] dblA;
	logic [2*`WORD_W-1:0] rolFull;
	logic [2*`WORD_W-1:0] rorFull;
	logic [3:0] shAmt;
	logic isEq;
	logic isLt;

	always_comb begin
		case (ctrl.immSel)
			IMM_ZE5: imm = {{(`WORD_W-5){1'b0}}, instr[4:0]};
			IMM_SE5: imm = {{(`WORD_W-5){instr[4]}}, instr[4:0]};
			IMM_SE8: imm = {{(`WORD_W-8){instr[7]}}, instr[7:0]};
			IMM_ZE8: imm = {{(`WORD_W-8){1'b0}}, instr[7:0]};
			default: imm = {{(`WORD_W-11){instr[10]}}, instr[10:0]};
		endcase
	end

	assign opB = ctrl.aluSrc ? imm : rtData;

	// One adder serves add, addresses and carry-out
	assign sumFull = {1'b0, rsData} + {1'b0, opB};

	assign shAmt = opB[3:0];
	assign dblA = {rsData, rsData};
	assign rolFull = dblA << shAmt;
	assign rorFull = dblA >> shAmt;

	assign isEq = (rsData == opB);
	assign isLt = ($signed(rsData) < $signed(opB));

	always_comb begin
		for (int i = 0; i < `WORD_W; i++) begin
			btrA[i] = rsData[`WORD_W-1-i];
		end
	end

	always_comb begin
		case (ctrl.aluOp)
			ALU_ADD: aluResult = sumFull[`WORD_W-1:0];
			// B minus A
			ALU_SUBR: aluResult = opB - rsData;
			ALU_XOR: aluResult = rsData ^ opB;
			ALU_AND: aluResult = rsData & opB;
			ALU_ANDN: aluResult = rsData & ~opB;
			ALU_ROL: aluResult = rolFull[2*`WORD_W-1:`WORD_W];
			ALU_SLL: aluResult = rsData << shAmt;
			ALU_ROR: aluResult = rorFull[`WORD_W-1:0];
			ALU_SRL: aluResult = rsData >> shAmt;
			ALU_SEQ: aluResult = {{(`WORD_W-1){1'b0}}, isEq};
			ALU_SLT: aluResult = {{(`WORD_W-1){1'b0}}, isLt};
			ALU_SLE: aluResult = {{(`WORD_W-1){1'b0}}, isLt | isEq};
			ALU_SCO: aluResult = {{(`WORD_W-1){1'b0}}, sumFull[`WORD_W]};
			ALU_BTR: aluResult = btrA;
			ALU_PASSB: aluResult = opB;
			default: aluResult = {rsData[`WORD_W-9:0], 8'h00} | opB;
		endcase
	end

endmodule

/* src/fetch.sv */
// Program counter, branch test, next-PC select and halt latch
`timescale 1ns/1ns
`include "wisc_defs.svh"

module fetch (
	input logic clk,
	input logic arstN,
	ctrlIf.datapath ctrl,
	input logic [`WORD_W-1:0] instr,
	input logic [`WORD_W-1:0] rsData,
	input logic [`WORD_W-1:0] aluResult,
	output logic [`WORD_W-1:0] pc,
	output logic [`WORD_W-1:0] pcPlus2,
	output logic halted
);
	import wiscPkg::*;

	logic [`WORD_W-1:0] brOffset;
	logic [`WORD_W-1:0] jmpOffset;
	logic [`WORD_W-1:0] nextPc;
	logic taken;

	assign pcPlus2 = pc + `WORD_W'd2;
	assign brOffset = {{(`WORD_W-8){instr[7]}}, instr[7:0]};
	assign jmpOffset = {{(`WORD_W-11){instr[10]}}, instr[10:0]};

	always_comb begin
		case (ctrl.brCond)
			BR_EQZ: taken = (rsData == '0);
			BR_NEZ: taken = (rsData != '0);
			BR_LTZ: taken = rsData[`WORD_W-1];
			BR_GEZ: taken = ~rsData[`WORD_W-1];
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		// Halt holds the PC on its own address
		if (halted || ctrl.halt) nextPc = pc;
		else if (ctrl.jump && ctrl.jumpReg) nextPc = aluResult;
		else if (ctrl.jump) nextPc = pcPlus2 + jmpOffset;
		else if (taken) nextPc = pcPlus2 + brOffset;
		else nextPc = pcPlus2;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= `RESET_PC;
			halted <= 1'b0;
		end else begin
			pc <= nextPc;
			if (ctrl.halt) halted <= 1'b1;
		end
	end

endmodule

/* src/wiscCore.sv */
// Single-cycle 16-bit core with external instruction and data memory ports
`timescale 1ns/1ns
`include "wisc_defs.svh"

module wiscCore (
	input logic clk,
	input logic arstN,
	input logic [`WORD_W-1:0] instrData,
	input logic [`WORD_W-1:0] dataRdData,
	output logic [`WORD_W-1:0] instrAddr,
	output logic [`WORD_W-1:0] dataAddr,
	output logic [`WORD_W-1:0] dataWrData,
	output logic dataWe,
	output logic dataRe,
	output logic halted
);
	import wiscPkg::*;

	logic [`WORD_W-1:0] rsData;
	logic [`WORD_W-1:0] rtData;
	logic [`WORD_W-1:0] aluResult;
	logic [`WORD_W-1:0] pcPlus2;
	logic [`WORD_W-1:0] wrData;
	logic [`REG_IDX_W-1:0] wrAddr;
	logic wrEn;

	ctrlIf ctrlBus ();

	control decoderInst (
		.instr(instrData),
		.ctrl(ctrlBus.decoder)
	);

	// Destination register field
	always_comb begin
		case (ctrlBus.destSel)
			DEST_RT: wrAddr = instrData[7:5];
			DEST_RD: wrAddr = instrData[4:2];
			DEST_RS: wrAddr = instrData[10:8];
			default: wrAddr = `REG_IDX_W'(7);
		endcase
	end

	always_comb begin
		case (ctrlBus.wbSel)
			WB_MEM: wrData = dataRdData;
			WB_LINK: wrData = pcPlus2;
			default: wrData = aluResult;
		endcase
	end

	assign wrEn = ctrlBus.regWrite & ~halted;

	regFile regFileInst (
		.clk(clk),
		.arstN(arstN),
		.rdAddrA(instrData[10:8]),
		.rdAddrB(instrData[7:5]),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdDataA(rsData),
		.rdDataB(rtData)
	);

	execute executeInst (
		.instr(instrData),
		.ctrl(ctrlBus.datapath),
		.rsData(rsData),
		.rtData(rtData),
		.aluResult(aluResult)
	);

	fetch fetchInst (
		.clk(clk),
		.arstN(arstN),
		.ctrl(ctrlBus.datapath),
		.instr(instrData),
		.rsData(rsData),
		.aluResult(aluResult),
		.pc(instrAddr),
		.pcPlus2(pcPlus2),
		.halted(halted)
	);

	// Memory strobes stay low once halted
	assign dataAddr = aluResult;
	assign dataWrData = rtData;
	assign dataWe = ctrlBus.memWrite & ~halted;
	assign dataRe = ctrlBus.memRead & ~halted;

endmodule

/* bench/clockGen.sv */
// Testbench clock and reset source with a 4 ns period and a 10-cycle reset
`timescale 1ns/1ns

module clockGen #(
	parameter int HALF_NS = 2
) (
	input logic reqReset,
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #HALF_NS clk = ~clk;
	end

	// Reset pulse on every request, released just after a rising edge
	initial begin
		arstN = 1'b0;
		forever begin
			@(posedge reqReset);
			arstN = 1'b0;
			repeat (10) @(posedge clk);
			#1 arstN = 1'b1;
		end
	end

endmodule

/* bench/coreBench.sv */
// Testbench for the core with random programs, memories and an ISA model
`timescale 1ns/1ns
`include "wisc_defs.svh"

module coreBench;
	import wiscPkg::*;

	localparam int NUM_PROGS = 20;
	localparam int PROG_LEN = 64;
	localparam int MAX_CYC = 300;
	localparam int WATCHDOG_NS = NUM_PROGS * (MAX_CYC + 16) * 4 + 2000;

	logic clk;
	logic arstN;
	logic reqReset;
	logic [`WORD_W-1:0] instrData;
	logic [`WORD_W-1:0] dataRdData;
	logic [`WORD_W-1:0] instrAddr;
	logic [`WORD_W-1:0] dataAddr;
	logic [`WORD_W-1:0] dataWrData;
	logic dataWe;
	logic dataRe;
	logic halted;

	logic [15:0] instrMem [128];
	logic [15:0] dataMem [256];

	// Model state
	logic [15:0] mRegs [8];
	logic [15:0] mMem [256];
	logic [15:0] mPc;
	logic mHalted;
	logic expWe;
	logic expRe;
	logic [15:0] expAddr;
	logic [15:0] expData;

	logic [31:0] lfsr;
	int errors;
	int checks;

	clockGen clockGenInst (
		.reqReset(reqReset),
		.clk(clk),
		.arstN(arstN)
	);

	wiscCore wiscCore_inst (
		.clk(clk),
		.arstN(arstN),
		.instrData(instrData),
		.dataRdData(dataRdData),
		.instrAddr(instrAddr),
		.dataAddr(dataAddr),
		.dataWrData(dataWrData),
		.dataWe(dataWe),
		.dataRe(dataRe),
		.halted(halted)
	);

	assign instrData = instrMem[instrAddr[7:1]];
	assign dataRdData = dataMem[dataAddr[7:0]];

	// Taps 32, 22, 2, 1
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[14:0], fb};
		end
		return r;
	endfunction

	function automatic logic [15:0] rotL(input logic [15:0] x, input logic [3:0] n);
		return (x << n) | (x >> (5'd16 - {1'b0, n}));
	endfunction

	function automatic logic [15:0] rotR(input logic [15:0] x, input logic [3:0] n);
		return (x >> n) | (x << (5'd16 - {1'b0, n}));
	endfunction

	function automatic logic [15:0] reverseBits(input logic [15:0] x);
		logic [15:0] r;
		r = {<<{x}};
		return r;
	endfunction

	task automatic compareValue(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic requireTrue(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Failure at %0t: %s", $time, what);
		end
	endtask

	// Setup, random body with short forward branches, register dump, halt
	task automatic buildProgram();
		logic [15:0] w;
		logic [4:0] op;
		logic [2:0] ri;
		for (int i = 0; i < 128; i++) begin
			instrMem[i] = '0;
		end
		for (int i = 0; i < 8; i++) begin
			ri = i[2:0];
			w = randBits(16);
			instrMem[i] = {OP_LBI, ri, w[7:0]};
			instrMem[i+8] = {OP_SLBI, ri, w[15:8]};
		end
		for (int i = 16; i < PROG_LEN - 10; i++) begin
			w = randBits(16);
			op = w[15:11];
			if (op == OP_HALT) op = OP_NOP;
			if (op inside {OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ}) w[7:0] = {4'b0, w[3:1], 1'b0};
			if (op == OP_J || op == OP_JAL) w[10:0] = {7'b0, w[3:1], 1'b0};
			instrMem[i] = {op, w[10:0]};
		end
		for (int i = 0; i < 8; i++) begin
			ri = i[2:0];
			instrMem[PROG_LEN-10+i] = {OP_ST, 3'd0, ri, 2'b00, ri};
		end
	endtask

	task automatic loadDataAndModel();
		logic [7:0] a;
		for (int i = 0; i < 256; i++) begin
			a = i[7:0];
			dataMem[i] = {a ^ 8'h5a, ~a};
			mMem[i] = {a ^ 8'h5a, ~a};
		end
		for (int i = 0; i < 8; i++) begin
			mRegs[i] = '0;
		end
		mPc = `RESET_PC;
		mHalted = 1'b0;
	endtask

	task automatic stepModel();
		logic [15:0] ins, a, b, se5, ze5, se8, se11, addr, nxt, res;
		logic [2:0] s, t, d, wa;
		logic wr;
		opcodeT op;
		ins = instrMem[mPc[7:1]];
		op = opcodeT'(ins[15:11]);
		s = ins[10:8];
		t = ins[7:5];
		d = ins[4:2];
		a = mRegs[s];
		b = mRegs[t];
		se5 = {{11{ins[4]}}, ins[4:0]};
		ze5 = {11'd0, ins[4:0]};
		se8 = {{8{ins[7]}}, ins[7:0]};
		se11 = {{5{ins[10]}}, ins[10:0]};
		addr = a + se5;
		nxt = mPc + 16'd2;
		expWe = 1'b0;
		expRe = 1'b0;
		expAddr = addr;
		expData = b;
		wr = 1'b1;
		wa = t;
		res = '0;
		case (op)
			OP_HALT: begin
				mHalted = 1'b1;
				nxt = mPc;
				wr = 1'b0;
			end
			OP_J, OP_JAL: begin
				nxt = mPc + 16'd2 + se11;
				wr = (op == OP_JAL);
				wa = 3'd7;
				res = mPc + 16'd2;
			end
			OP_JR, OP_JALR: begin
				nxt = a + se8;
				wr = (op == OP_JALR);
				wa = 3'd7;
				res = mPc + 16'd2;
			end
			OP_ADDI: res = a + se5;
			OP_SUBI: res = se5 - a;
			OP_XORI: res = a ^ ze5;
			OP_ANDI: res = a & ze5;
			OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
				wr = 1'b0;
				if ((op == OP_BEQZ && a == 16'd0) || (op == OP_BNEZ && a != 16'd0) ||
						(op == OP_BLTZ && a[15]) || (op == OP_BGEZ && !a[15]))
					nxt = mPc + 16'd2 + se8;
			end
			OP_ST, OP_STU: begin
				expWe = 1'b1;
				mMem[addr[7:0]] = b;
				wr = (op == OP_STU);
				wa = s;
				res = addr;
			end
			OP_LD: begin
				expRe = 1'b1;
				res = mMem[addr[7:0]];
			end
			OP_SLBI: begin
				wa = s;
				res = {a[7:0], ins[7:0]};
			end
			OP_LBI: begin
				wa = s;
				res = se8;
			end
			OP_ROLI: res = rotL(a, ins[3:0]);
			OP_SLLI: res = a << ins[3:0];
			OP_RORI: res = rotR(a, ins[3:0]);
			OP_SRLI: res = a >> ins[3:0];
			OP_BTR: begin
				wa = d;
				res = reverseBits(a);
			end
			OP_RTYPE_SHIFT: begin
				wa = d;
				case (ins[1:0])
					2'b00: res = rotL(a, b[3:0]);
					2'b01: res = a << b[3:0];
					2'b10: res = rotR(a, b[3:0]);
					default: res = a >> b[3:0];
				endcase
			end
			OP_RTYPE_ARITH: begin
				wa = d;
				case (ins[1:0])
					2'b00: res = a + b;
					2'b01: res = b - a;
					2'b10: res = a ^ b;
					default: res = a & ~b;
				endcase
			end
			OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
				wa = d;
				if (op == OP_SEQ) res = {15'd0, a == b};
				else if (op == OP_SLT) res = {15'd0, $signed(a) < $signed(b)};
				else if (op == OP_SLE) res = {15'd0, $signed(a) <= $signed(b)};
				// Unsigned wrap of the 16-bit sum means a carry
				else res = {15'd0, (a + b) < a};
			end
			// nop, siic, rti
			default: wr = 1'b0;
		endcase
		if (wr) mRegs[wa] = res;
		mPc = nxt;
	endtask

	task automatic runProgram();
		int cyc;
		int haltSeen;
		logic [15:0] stuWord;
		logic [15:0] ldWord;
		cyc = 0;
		haltSeen = 0;
		stuWord = {OP_STU, 3'd1, 3'd2, 5'd0};
		ldWord = {OP_LD, 3'd1, 3'd2, 5'd0};
		while (cyc < MAX_CYC && haltSeen < 3) begin
			@(negedge clk);
			cyc++;
			if (mHalted) begin
				requireTrue(halted, "halted did not rise after the halt instruction");
				compareValue("instrAddr", instrAddr, mPc);
				requireTrue(!dataWe && !dataRe, "memory strobe high while halted");
				haltSeen++;
				// A stu and then an ld on the frozen address must stay inert
				if (haltSeen < 3) begin
					@(posedge clk);
					#1 instrMem[mPc[7:1]] = (haltSeen == 1) ? stuWord : ldWord;
				end
			end else begin
				requireTrue(!halted, "halted is high before any halt instruction");
				compareValue("instrAddr", instrAddr, mPc);
				stepModel();
				compareValue("dataWe", {15'd0, dataWe}, {15'd0, expWe});
				compareValue("dataRe", {15'd0, dataRe}, {15'd0, expRe});
				if (expWe) begin
					compareValue("dataAddr", dataAddr, expAddr);
					compareValue("dataWrData", dataWrData, expData);
				end
				// Store lands at the coming edge
				if (dataWe) dataMem[dataAddr[7:0]] = dataWrData;
			end
		end
	endtask

	initial begin
		#WATCHDOG_NS;
		$display("Watchdog expired before all programs finished");
		$display("Errors found");
		$finish;
	end

	initial begin
		lfsr = 32'h6caec852;
		errors = 0;
		checks = 0;
		reqReset = 1'b0;
		for (int i = 0; i < 128; i++) begin
			instrMem[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			dataMem[i] = '0;
		end
		for (int p = 0; p < NUM_PROGS; p++) begin
			@(posedge clk);
			#1 reqReset = 1'b1;
			#1 reqReset = 1'b0;
			buildProgram();
			loadDataAndModel();
			wait (arstN === 1'b1);
			compareValue("instrAddr", instrAddr, `RESET_PC);
			requireTrue(!halted, "halted is high directly after reset");
			runProgram();
		end
		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* wisc.f */
+incdir+include
src/wiscPkg.sv
src/ctrlIf.sv
src/control.sv
src/regFile.sv
src/execute.sv
src/fetch.sv
src/wiscCore.sv
bench/clockGen.sv
bench/coreBench.sv

/* Makefile */
# Verilator build and run of the core testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f wisc.f --top-module coreBench -Mdir obj_dir
	./obj_dir/VcoreBench > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "FAIL"; exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
